// ==== ldu_addr.f ====
ldu_addr_pkg.sv
ldu_operand_select.sv
ldu_agu.sv
ldu_addr_pipeline.sv
ldu_addr_pipeline_wrapper.sv
tb_clock.sv
tb_ldu_addr_assert.sv
tb_ldu_addr.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the load address pipeline testbench with Verilator
set -eo pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
	-f ldu_addr.f \
	--top-module tb_ldu_addr \
	-o tb_ldu_addr_sim

./obj_dir/tb_ldu_addr_sim | tee "$LOG"

if grep -q '\*\*\* TEST FAILED \*\*\*' "$LOG"; then
	echo "simulation reported failure, see $LOG"
	exit 1
fi

echo "simulation finished without failure"

// ==== tb_ldu_addr.sv ====
`timescale 1ns/1ps

module tb_ldu_addr;

	localparam int CLK_PERIOD = 8;
	localparam int TEST_COUNT = 5;
	localparam int CYCLES_PER_TEST = 200;
	// cycles to wait for a request before giving up
	localparam int REQ_WAIT_LIMIT = 40;

	logic CLK;
	logic nRST;

	// ---------------------------------------------------------------------
	// DUT ports

	logic next_issue_valid;
	ldu_addr_pkg::load_op_t next_issue_op;
	ldu_addr_pkg::imm12_t next_issue_imm12;
	logic next_issue_A_forward;
	logic next_issue_A_is_zero;
	ldu_addr_pkg::prf_bank_t next_issue_A_bank;
	ldu_addr_pkg::cq_index_t next_issue_cq_index;
	logic last_issue_ready;
	logic next_A_reg_read_ack;
	logic next_A_reg_read_port;
	ldu_addr_pkg::word_t [ldu_addr_pkg::PRF_BANK_COUNT-1:0][1:0]
		next_reg_read_data_by_bank_by_port;
	ldu_addr_pkg::word_t [ldu_addr_pkg::PRF_BANK_COUNT-1:0] next_forward_data_by_bank;
	logic last_REQ_valid_cq;
	logic last_REQ_valid_mq;
	logic last_REQ_misaligned;
	ldu_addr_pkg::vpn_t last_REQ_VPN;
	ldu_addr_pkg::po_word_t last_REQ_PO_word;
	ldu_addr_pkg::byte_mask_t last_REQ_byte_mask;
	ldu_addr_pkg::cq_index_t last_REQ_cq_index;
	logic next_REQ_ack;

	// bookkeeping
	int seed = 34681;
	int err_cnt = 0;
	int check_cnt = 0;
	int test_err_base = 0;
	int cycle_cnt = 0;
	int issue_cycle = 0;
	string test_name;

	tb_clock u_clock (
		.CLK(CLK),
		.nRST(nRST)
	);

	ldu_addr_pipeline_wrapper dut (
		.CLK(CLK),
		.nRST(nRST),
		.next_issue_valid(next_issue_valid),
		.next_issue_op(next_issue_op),
		.next_issue_imm12(next_issue_imm12),
		.next_issue_A_forward(next_issue_A_forward),
		.next_issue_A_is_zero(next_issue_A_is_zero),
		.next_issue_A_bank(next_issue_A_bank),
		.next_issue_cq_index(next_issue_cq_index),
		.last_issue_ready(last_issue_ready),
		.next_A_reg_read_ack(next_A_reg_read_ack),
		.next_A_reg_read_port(next_A_reg_read_port),
		.next_reg_read_data_by_bank_by_port(next_reg_read_data_by_bank_by_port),
		.next_forward_data_by_bank(next_forward_data_by_bank),
		.last_REQ_valid_cq(last_REQ_valid_cq),
		.last_REQ_valid_mq(last_REQ_valid_mq),
		.last_REQ_misaligned(last_REQ_misaligned),
		.last_REQ_VPN(last_REQ_VPN),
		.last_REQ_PO_word(last_REQ_PO_word),
		.last_REQ_byte_mask(last_REQ_byte_mask),
		.last_REQ_cq_index(last_REQ_cq_index),
		.next_REQ_ack(next_REQ_ack)
	);

	// rising edges since time zero
	always @(posedge CLK) begin
		cycle_cnt <= cycle_cnt + 1;
	end

	// ---------------------------------------------------------------------
	// reporting and compares

	task automatic report_mismatch(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		err_cnt++;
		$display("ERR %0t %s got 0x%0h expected 0x%0h", $time, name, got, expected);
	endtask

	task automatic report_failure(input string what);
		err_cnt++;
		$display("error at %0t: %s", $time, what);
	endtask

	task automatic cmp_bit(input string name, input logic got, input logic expected);
		check_cnt++;
		if (got !== expected) begin
			report_mismatch(name, 32'(got), 32'(expected));
		end
	endtask

	// every request field against the model
	task automatic cmp_req(input ldu_addr_pkg::ldu_req_t exp_req);
		check_cnt++;
		if (last_REQ_valid_cq !== exp_req.valid_cq) begin
			report_mismatch("last_REQ_valid_cq", 32'(last_REQ_valid_cq), 32'(exp_req.valid_cq));
		end
		if (last_REQ_valid_mq !== exp_req.valid_mq) begin
			report_mismatch("last_REQ_valid_mq", 32'(last_REQ_valid_mq), 32'(exp_req.valid_mq));
		end
		if (last_REQ_misaligned !== exp_req.misaligned) begin
			report_mismatch("last_REQ_misaligned", 32'(last_REQ_misaligned),
				32'(exp_req.misaligned));
		end
		if (last_REQ_VPN !== exp_req.VPN) begin
			report_mismatch("last_REQ_VPN", 32'(last_REQ_VPN), 32'(exp_req.VPN));
		end
		if (last_REQ_PO_word !== exp_req.PO_word) begin
			report_mismatch("last_REQ_PO_word", 32'(last_REQ_PO_word), 32'(exp_req.PO_word));
		end
		if (last_REQ_byte_mask !== exp_req.byte_mask) begin
			report_mismatch("last_REQ_byte_mask", 32'(last_REQ_byte_mask),
				32'(exp_req.byte_mask));
		end
		if (last_REQ_cq_index !== exp_req.cq_index) begin
			report_mismatch("last_REQ_cq_index", 32'(last_REQ_cq_index), 32'(exp_req.cq_index));
		end
	endtask

	task automatic start_test(input string name);
		test_name = name;
		test_err_base = err_cnt;
	endtask

	task automatic end_test();
		int errs;
		errs = err_cnt - test_err_base;
		if (errs == 0) begin
			$display("test %s: ok", test_name);
		end else begin
			$display("test %s: %0d error(s)", test_name, errs);
		end
	endtask

	// ---------------------------------------------------------------------
	// reference model

	task automatic model_req(input ldu_addr_pkg::word_t a, input ldu_addr_pkg::load_op_t op,
		input ldu_addr_pkg::imm12_t imm, input ldu_addr_pkg::cq_index_t cq,
		output ldu_addr_pkg::ldu_req_t r);
		int offset;
		ldu_addr_pkg::word_t addr;
		// immediate as a signed byte offset
		offset = int'($signed(imm));
		addr = a + ldu_addr_pkg::word_t'(offset);
		r = '0;
		r.valid_cq = 1'b1;
		r.VPN = addr[31:12];
		r.PO_word = addr[11:2];
		r.cq_index = cq;
		case (op[1:0])
			2'd0: begin
				r.byte_mask = '0;
				r.byte_mask[addr[1:0]] = 1'b1;
			end
			2'd1: begin
				// top byte lost at offset 3
				case (addr[1:0])
					2'd0: r.byte_mask = 4'b0011;
					2'd1: r.byte_mask = 4'b0110;
					2'd2: r.byte_mask = 4'b1100;
					default: r.byte_mask = 4'b1000;
				endcase
				r.misaligned = addr[0];
			end
			default: begin
				r.byte_mask = 4'b1111;
				r.misaligned = (addr[1:0] != 2'b00);
			end
		endcase
		r.valid_mq = r.misaligned;
	endtask

	// ---------------------------------------------------------------------
	// drive helpers

	task automatic drive_issue(input ldu_addr_pkg::load_op_t op, input ldu_addr_pkg::imm12_t imm,
		input logic fwd, input logic zero, input ldu_addr_pkg::prf_bank_t bank,
		input ldu_addr_pkg::cq_index_t cq);
		next_issue_valid = 1'b1;
		next_issue_op = op;
		next_issue_imm12 = imm;
		next_issue_A_forward = fwd;
		next_issue_A_is_zero = zero;
		next_issue_A_bank = bank;
		next_issue_cq_index = cq;
	endtask

	// one sampling edge, returns between E0 and E1
	task automatic issue_op(input ldu_addr_pkg::load_op_t op, input ldu_addr_pkg::imm12_t imm,
		input logic fwd, input logic zero, input ldu_addr_pkg::prf_bank_t bank,
		input ldu_addr_pkg::cq_index_t cq);
		@(negedge CLK);
		drive_issue(op, imm, fwd, zero, bank, cq);
		@(negedge CLK);
		next_issue_valid = 1'b0;
		issue_cycle = cycle_cnt;
	endtask

	task automatic ack_req();
		next_REQ_ack = 1'b1;
		@(negedge CLK);
		next_REQ_ack = 1'b0;
	endtask

	// poll for a request, latency counted from the issue edge
	task automatic wait_req(input int exp_lat, output logic found);
		int waited;
		waited = 0;
		found = 1'b0;
		while (!found && waited < REQ_WAIT_LIMIT) begin
			if (last_REQ_valid_cq === 1'b1) begin
				found = 1'b1;
			end else begin
				@(negedge CLK);
				waited++;
			end
		end
		if (!found) begin
			report_failure("request did not appear on last_REQ_valid_cq");
		end else if (exp_lat >= 0) begin
			check_cnt++;
			if (cycle_cnt - issue_cycle != exp_lat) begin
				report_mismatch("request latency", 32'(cycle_cnt - issue_cycle), 32'(exp_lat));
			end
		end
	endtask

	task automatic complete_req(input ldu_addr_pkg::ldu_req_t exp_req, input int exp_lat);
		logic found;
		wait_req(exp_lat, found);
		if (found) begin
			cmp_req(exp_req);
			ack_req();
			// valid drops two edges after the ack is sampled
			@(negedge CLK);
			@(negedge CLK);
			cmp_bit("last_REQ_valid_cq", last_REQ_valid_cq, 1'b0);
		end
	endtask

	// ---------------------------------------------------------------------
	// directed tests

	task automatic test_reset_zero();
		ldu_addr_pkg::ldu_req_t exp_req;
		ldu_addr_pkg::imm12_t imm;
		start_test("reset_zero");
		@(negedge CLK);
		cmp_bit("last_issue_ready", last_issue_ready, 1'b0);
		wait (nRST === 1'b1);
		@(posedge CLK);
		@(negedge CLK);
		cmp_bit("last_issue_ready", last_issue_ready, 1'b1);
		cmp_bit("last_REQ_valid_cq", last_REQ_valid_cq, 1'b0);
		cmp_bit("last_REQ_valid_mq", last_REQ_valid_mq, 1'b0);
		// negative immediate off a zero base
		imm = 12'h800 | ldu_addr_pkg::imm12_t'($random(seed));
		model_req('0, 4'd2, imm, 4'd5, exp_req);
		issue_op(4'd2, imm, 1'b0, 1'b1, '0, 4'd5);
		complete_req(exp_req, 3);
		end_test();
	endtask

	task automatic test_forward();
		ldu_addr_pkg::ldu_req_t exp_req;
		ldu_addr_pkg::imm12_t imm;
		ldu_addr_pkg::load_op_t op;
		start_test("forward");
		for (int b = 0; b < ldu_addr_pkg::PRF_BANK_COUNT; b++) begin
			imm = ldu_addr_pkg::imm12_t'($random(seed));
			op = ldu_addr_pkg::load_op_t'($random(seed));
			issue_op(op, imm, 1'b1, 1'b0, ldu_addr_pkg::prf_bank_t'(b),
				ldu_addr_pkg::cq_index_t'(b + 1));
			// bypass data has to be there for E1
			for (int k = 0; k < ldu_addr_pkg::PRF_BANK_COUNT; k++) begin
				next_forward_data_by_bank[k] = $random(seed);
			end
			model_req(next_forward_data_by_bank[b], op, imm,
				ldu_addr_pkg::cq_index_t'(b + 1), exp_req);
			complete_req(exp_req, 3);
		end
		end_test();
	endtask

	task automatic test_reg_read();
		ldu_addr_pkg::ldu_req_t exp_req;
		ldu_addr_pkg::imm12_t imm;
		ldu_addr_pkg::load_op_t op;
		ldu_addr_pkg::prf_bank_t bank;
		logic port;
		int w;
		start_test("reg_read");
		for (int i = 0; i < 6; i++) begin
			imm = ldu_addr_pkg::imm12_t'($random(seed));
			op = ldu_addr_pkg::load_op_t'($random(seed));
			bank = ldu_addr_pkg::prf_bank_t'($random(seed));
			port = 1'($random(seed));
			w = int'($unsigned($random(seed)) % 5);
			issue_op(op, imm, 1'b0, 1'b0, bank, ldu_addr_pkg::cq_index_t'(i + 8));
			// nothing may come out before the ack
			repeat (w) begin
				cmp_bit("last_REQ_valid_cq", last_REQ_valid_cq, 1'b0);
				@(negedge CLK);
			end
			for (int k = 0; k < ldu_addr_pkg::PRF_BANK_COUNT; k++) begin
				next_reg_read_data_by_bank_by_port[k][0] = $random(seed);
				next_reg_read_data_by_bank_by_port[k][1] = $random(seed);
			end
			next_A_reg_read_port = port;
			next_A_reg_read_ack = 1'b1;
			model_req(next_reg_read_data_by_bank_by_port[bank][port], op, imm,
				ldu_addr_pkg::cq_index_t'(i + 8), exp_req);
			@(negedge CLK);
			next_A_reg_read_ack = 1'b0;
			complete_req(exp_req, 3 + w);
		end
		end_test();
	endtask

	task automatic test_sizes();
		ldu_addr_pkg::ldu_req_t exp_req;
		ldu_addr_pkg::imm12_t imm;
		ldu_addr_pkg::load_op_t op;
		ldu_addr_pkg::word_t a;
		start_test("sizes");
		for (int size = 0; size < 4; size++) begin
			for (int off = 0; off < 4; off++) begin
				imm = ldu_addr_pkg::imm12_t'($random(seed));
				a = $random(seed);
				// pick the base so the sum lands on this offset
				a[1:0] = 2'(off) - imm[1:0];
				// unsigned bit is noise for the address
				op = {1'b0, 1'($random(seed)), 2'(size)};
				issue_op(op, imm, 1'b1, 1'b0, ldu_addr_pkg::prf_bank_t'(off),
					ldu_addr_pkg::cq_index_t'(size * 4 + off));
				next_forward_data_by_bank[off] = a;
				model_req(a, op, imm, ldu_addr_pkg::cq_index_t'(size * 4 + off), exp_req);
				complete_req(exp_req, 3);
			end
		end
		end_test();
	endtask

	task automatic test_backpressure();
		ldu_addr_pkg::ldu_req_t exp_a;
		ldu_addr_pkg::ldu_req_t exp_b;
		ldu_addr_pkg::imm12_t imm_b;
		ldu_addr_pkg::word_t data_b;
		logic found;
		start_test("backpressure");
		imm_b = ldu_addr_pkg::imm12_t'($random(seed));
		data_b = $random(seed);
		model_req('0, 4'd2, 12'hff4, 4'd9, exp_a);
		model_req(data_b, 4'd1, imm_b, 4'd10, exp_b);
		// load A from zero, load B forwarded from bank 2 right behind it
		@(negedge CLK);
		drive_issue(4'd2, 12'hff4, 1'b0, 1'b1, '0, 4'd9);
		@(negedge CLK);
		issue_cycle = cycle_cnt;
		drive_issue(4'd1, imm_b, 1'b1, 1'b0, 2'd2, 4'd10);
		@(negedge CLK);
		next_issue_valid = 1'b0;
		next_forward_data_by_bank[2] = data_b;
		// bypass gone after B's first cycle, OC must keep its copy
		@(negedge CLK);
		next_forward_data_by_bank[2] = ~data_b;
		wait_req(3, found);
		if (found) begin
			cmp_req(exp_a);
			// no ack, both stages stay full
			repeat (4) begin
				@(negedge CLK);
			end
			cmp_bit("last_issue_ready", last_issue_ready, 1'b0);
			cmp_req(exp_a);
			ack_req();
			@(negedge CLK);
			@(negedge CLK);
			cmp_req(exp_b);
			ack_req();
			@(negedge CLK);
			@(negedge CLK);
			cmp_bit("last_REQ_valid_cq", last_REQ_valid_cq, 1'b0);
			cmp_bit("last_issue_ready", last_issue_ready, 1'b1);
		end
		end_test();
	endtask

	// ---------------------------------------------------------------------
	// main sequence and watchdog

	initial begin
		next_issue_valid = 1'b0;
		next_issue_op = '0;
		next_issue_imm12 = '0;
		next_issue_A_forward = 1'b0;
		next_issue_A_is_zero = 1'b0;
		next_issue_A_bank = '0;
		next_issue_cq_index = '0;
		next_A_reg_read_ack = 1'b0;
		next_A_reg_read_port = 1'b0;
		next_reg_read_data_by_bank_by_port = '0;
		next_forward_data_by_bank = '0;
		next_REQ_ack = 1'b0;

		test_reset_zero();
		test_forward();
		test_reg_read();
		test_sizes();
		test_backpressure();

		$display("summary: %0d checks, %0d errors", check_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

	// budget of 200 cycles per test
	initial begin
		#(TEST_COUNT * CYCLES_PER_TEST * CLK_PERIOD);
		$display("watchdog: run did not finish in %0d cycles", TEST_COUNT * CYCLES_PER_TEST);
		$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

// ==== tb_ldu_addr_assert.sv ====
`timescale 1ns/1ps

module tb_ldu_addr_assert (
	input logic CLK,
	input logic nRST,
	input ldu_addr_pkg::ldu_req_t REQ,
	input logic REQ_ack,
	input logic issue_ready,
	input ldu_addr_pkg::oc_state_t oc_state
);

	// stalled request keeps every field
	req_hold_stable: assert property (
		@(posedge CLK) disable iff (!nRST)
		(REQ.valid_cq && !REQ_ack) |=> $stable(REQ)
	) else $error("REQ changed while stalled without ack");

	// misaligned queue only together with the completion queue
	req_mq_implies_cq: assert property (
		@(posedge CLK) disable iff (!nRST)
		REQ.valid_mq |-> (REQ.valid_cq && REQ.misaligned)
	) else $error("valid_mq without valid_cq and misaligned");

	// both stages full and stuck
	issue_blocked_when_full: assert property (
		@(posedge CLK) disable iff (!nRST)
		((oc_state != ldu_addr_pkg::OC_EMPTY) && REQ.valid_cq && !REQ_ack) |-> !issue_ready
	) else $error("issue_ready high with OC occupied and REQ stalled");

endmodule

bind ldu_addr_pipeline tb_ldu_addr_assert u_assert (
	.CLK(CLK),
	.nRST(nRST),
	.REQ(REQ),
	.REQ_ack(REQ_ack),
	.issue_ready(issue_ready),
	.oc_state(oc_state)
);

// ==== tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
	output logic CLK,
	output logic nRST
);

	// 8 ns period
	localparam int HALF_PERIOD = 4;
	localparam int RESET_CYCLES = 3;

	initial begin
		CLK = 1'b0;
		forever begin
			#HALF_PERIOD CLK = ~CLK;
		end
	end

	// release lands on a falling edge
	initial begin
		nRST = 1'b0;
		#(2 * HALF_PERIOD * RESET_CYCLES) nRST = 1'b1;
	end

endmodule

// ==== ldu_addr_pipeline_wrapper.sv ====
`timescale 1ns/1ps

module ldu_addr_pipeline_wrapper (
	input logic CLK,
	input logic nRST,

	// op issue from the issue queue
	input logic next_issue_valid,
	input ldu_addr_pkg::load_op_t next_issue_op,
	input ldu_addr_pkg::imm12_t next_issue_imm12,
	input logic next_issue_A_forward,
	input logic next_issue_A_is_zero,
	input ldu_addr_pkg::prf_bank_t next_issue_A_bank,
	input ldu_addr_pkg::cq_index_t next_issue_cq_index,
	output logic last_issue_ready,

	// register read grant and data
	input logic next_A_reg_read_ack,
	input logic next_A_reg_read_port,
	input ldu_addr_pkg::word_t [ldu_addr_pkg::PRF_BANK_COUNT-1:0][1:0]
		next_reg_read_data_by_bank_by_port,

	// bypass data
	input ldu_addr_pkg::word_t [ldu_addr_pkg::PRF_BANK_COUNT-1:0]
		next_forward_data_by_bank,

	// request stage
	output logic last_REQ_valid_cq,
	output logic last_REQ_valid_mq,
	output logic last_REQ_misaligned,
	output ldu_addr_pkg::vpn_t last_REQ_VPN,
	output ldu_addr_pkg::po_word_t last_REQ_PO_word,
	output ldu_addr_pkg::byte_mask_t last_REQ_byte_mask,
	output ldu_addr_pkg::cq_index_t last_REQ_cq_index,
	input logic next_REQ_ack
);

	// ---------------------------------------------------------------------
	// registered inputs and pipeline outputs

	ldu_addr_pkg::ldu_issue_t issue;
	logic issue_ready;
	logic A_reg_read_ack;
	logic A_reg_read_port;
	ldu_addr_pkg::word_t [ldu_addr_pkg::PRF_BANK_COUNT-1:0][1:0] reg_read_data_by_bank_by_port;
	ldu_addr_pkg::word_t [ldu_addr_pkg::PRF_BANK_COUNT-1:0] forward_data_by_bank;
	ldu_addr_pkg::ldu_req_t REQ;
	logic REQ_ack;

	ldu_addr_pipeline u_pipeline (
		.CLK(CLK),
		.nRST(nRST),
		.issue(issue),
		.issue_ready(issue_ready),
		.A_reg_read_ack(A_reg_read_ack),
		.A_reg_read_port(A_reg_read_port),
		.reg_read_data_by_bank_by_port(reg_read_data_by_bank_by_port),
		.forward_data_by_bank(forward_data_by_bank),
		.REQ(REQ),
		.REQ_ack(REQ_ack)
	);

	// ---------------------------------------------------------------------
	// boundary flops, one stage each way

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			issue <= '0;
			A_reg_read_ack <= 1'b0;
			A_reg_read_port <= 1'b0;
			reg_read_data_by_bank_by_port <= '0;
			forward_data_by_bank <= '0;
			REQ_ack <= 1'b0;
			last_issue_ready <= 1'b0;
			last_REQ_valid_cq <= 1'b0;
			last_REQ_valid_mq <= 1'b0;
			last_REQ_misaligned <= 1'b0;
			last_REQ_VPN <= '0;
			last_REQ_PO_word <= '0;
			last_REQ_byte_mask <= '0;
			last_REQ_cq_index <= '0;
		end else begin
			// pack flat issue ports into the struct
			issue.valid <= next_issue_valid;
			issue.op <= next_issue_op;
			issue.imm12 <= next_issue_imm12;
			issue.A_forward <= next_issue_A_forward;
			issue.A_is_zero <= next_issue_A_is_zero;
			issue.A_bank <= next_issue_A_bank;
			issue.cq_index <= next_issue_cq_index;
			A_reg_read_ack <= next_A_reg_read_ack;
			A_reg_read_port <= next_A_reg_read_port;
			reg_read_data_by_bank_by_port <= next_reg_read_data_by_bank_by_port;
			forward_data_by_bank <= next_forward_data_by_bank;
			REQ_ack <= next_REQ_ack;
			last_issue_ready <= issue_ready;
			// unpack the request onto flat ports
			last_REQ_valid_cq <= REQ.valid_cq;
			last_REQ_valid_mq <= REQ.valid_mq;
			last_REQ_misaligned <= REQ.misaligned;
			last_REQ_VPN <= REQ.VPN;
			last_REQ_PO_word <= REQ.PO_word;
			last_REQ_byte_mask <= REQ.byte_mask;
			last_REQ_cq_index <= REQ.cq_index;
		end
	end

endmodule

// ==== ldu_addr_pipeline.sv ====
`timescale 1ns/1ps

module ldu_addr_pipeline (
	input logic CLK,
	input logic nRST,

	// op issue from the issue queue
	input ldu_addr_pkg::ldu_issue_t issue,
	output logic issue_ready,

	// register read grant and data
	input logic A_reg_read_ack,
	input logic A_reg_read_port,
	input ldu_addr_pkg::word_t [ldu_addr_pkg::PRF_BANK_COUNT-1:0][1:0]
		reg_read_data_by_bank_by_port,

	// bypass data per bank
	input ldu_addr_pkg::word_t [ldu_addr_pkg::PRF_BANK_COUNT-1:0] forward_data_by_bank,

	// request stage and its ack
	output ldu_addr_pkg::ldu_req_t REQ,
	input logic REQ_ack
);

	// ---------------------------------------------------------------------
	// signals

	// operand collect entry
	ldu_addr_pkg::oc_state_t oc_state;
	ldu_addr_pkg::oc_state_t oc_state_next;
	ldu_addr_pkg::ldu_issue_t oc_entry;
	logic oc_first_cycle;
	ldu_addr_pkg::word_t oc_held_operand;

	// operand select results
	logic sel_available;
	ldu_addr_pkg::word_t sel_operand;

	// stage control
	logic oc_valid;
	logic oc_available;
	logic oc_latch;
	logic oc_advance;
	logic req_free;
	logic issue_accept;
	ldu_addr_pkg::word_t oc_operand;

	// address for the OC entry
	ldu_addr_pkg::ldu_req_t agu_req;

	// ---------------------------------------------------------------------
	// operand collect stage

	ldu_operand_select u_operand_select (
		.entry(oc_entry),
		.first_cycle(oc_first_cycle),
		.A_reg_read_ack(A_reg_read_ack),
		.A_reg_read_port(A_reg_read_port),
		.reg_read_data_by_bank_by_port(reg_read_data_by_bank_by_port),
		.forward_data_by_bank(forward_data_by_bank),
		.operand_available(sel_available),
		.operand(sel_operand)
	);

	// WAIT_READ covers every fresh entry, HOLD means the operand is latched
	assign oc_valid = (oc_state != ldu_addr_pkg::OC_EMPTY);
	assign oc_available = (oc_state == ldu_addr_pkg::OC_HOLD) ||
		((oc_state == ldu_addr_pkg::OC_WAIT_READ) && sel_available);
	assign oc_operand = (oc_state == ldu_addr_pkg::OC_HOLD) ? oc_held_operand : sel_operand;

	// REQ can take a new entry if empty or leaving this cycle
	assign req_free = !REQ.valid_cq || REQ_ack;
	assign oc_advance = oc_available && req_free;

	// operand showed up but REQ is stuck, keep it before it goes away
	assign oc_latch = (oc_state == ldu_addr_pkg::OC_WAIT_READ) && sel_available && !req_free;

	// back to the issue queue
	assign issue_ready = !oc_valid || oc_advance;
	assign issue_accept = issue.valid && issue_ready;

	always_comb begin
		oc_state_next = oc_state;
		if (!oc_valid || oc_advance) begin
			oc_state_next = issue_accept ? ldu_addr_pkg::OC_WAIT_READ : ldu_addr_pkg::OC_EMPTY;
		end else if (oc_latch) begin
			oc_state_next = ldu_addr_pkg::OC_HOLD;
		end
	end

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			oc_state <= ldu_addr_pkg::OC_EMPTY;
			oc_first_cycle <= 1'b0;
		end else begin
			oc_state <= oc_state_next;
			// forward window is the cycle after acceptance only
			oc_first_cycle <= issue_accept;
		end
	end

	// entry payload and latched operand
	always_ff @(posedge CLK) begin
		if (issue_accept) begin
			oc_entry <= issue;
		end
		if (oc_latch) begin
			oc_held_operand <= sel_operand;
		end
	end

	// ---------------------------------------------------------------------
	// request stage

	ldu_agu u_agu (
		.operand(oc_operand),
		.op(oc_entry.op),
		.imm12(oc_entry.imm12),
		.cq_index(oc_entry.cq_index),
		.req(agu_req)
	);

	always_ff @(posedge CLK, negedge nRST) begin
		if (!nRST) begin
			REQ <= '0;
		end else if (oc_advance) begin
			// new entry replaces whatever is being acked
			REQ <= agu_req;
		end else if (REQ.valid_cq && REQ_ack) begin
			REQ.valid_cq <= 1'b0;
			REQ.valid_mq <= 1'b0;
		end
	end

endmodule

// ==== ldu_agu.sv ====
`timescale 1ns/1ps

module ldu_agu (
	input ldu_addr_pkg::word_t operand,
	input ldu_addr_pkg::load_op_t op,
	input ldu_addr_pkg::imm12_t imm12,
	input ldu_addr_pkg::cq_index_t cq_index,
	output ldu_addr_pkg::ldu_req_t req
);

	// ---------------------------------------------------------------------
	// address add

	ldu_addr_pkg::word_t imm_ext;
	ldu_addr_pkg::word_t addr;
	ldu_addr_pkg::byte_mask_t byte_mask;
	logic misaligned;

	// sign-extend the 12-bit immediate
	assign imm_ext = {{20{imm12[11]}}, imm12};
	assign addr = operand + imm_ext;

	// ---------------------------------------------------------------------
	// size decode

	always_comb begin
		// word by default, covers size 2 and 3
		byte_mask = 4'b1111;
		misaligned = |addr[1:0];

		case (op[1:0])
			2'd0: begin
				// single byte never crosses a word
				byte_mask = 4'b0001 << addr[1:0];
				misaligned = 1'b0;
			end
			2'd1: begin
				// upper half of the lane drops off at offset 3
				byte_mask = 4'b0011 << addr[1:0];
				misaligned = addr[0];
			end
			default: begin
				byte_mask = 4'b1111;
				misaligned = |addr[1:0];
			end
		endcase
	end

	// ---------------------------------------------------------------------
	// request fields

	assign req.valid_cq = 1'b1;
	// misaligned loads also go to the misaligned queue
	assign req.valid_mq = misaligned;
	assign req.misaligned = misaligned;
	assign req.VPN = addr[31:12];
	assign req.PO_word = addr[11:2];
	assign req.byte_mask = byte_mask;
	assign req.cq_index = cq_index;

endmodule

// ==== ldu_operand_select.sv ====
`timescale 1ns/1ps

module ldu_operand_select (
	// entry currently sitting in operand collect
	input ldu_addr_pkg::ldu_issue_t entry,
	input logic first_cycle,

	// register read result for this entry
	input logic A_reg_read_ack,
	input logic A_reg_read_port,
	input ldu_addr_pkg::word_t [ldu_addr_pkg::PRF_BANK_COUNT-1:0][1:0]
		reg_read_data_by_bank_by_port,

	// bypass data, one word per bank
	input ldu_addr_pkg::word_t [ldu_addr_pkg::PRF_BANK_COUNT-1:0] forward_data_by_bank,

	output logic operand_available,
	output ldu_addr_pkg::word_t operand
);

	// ---------------------------------------------------------------------
	// source select

	always_comb begin
		// default to the zero source, not available
		operand = '0;
		operand_available = 1'b0;

		if (entry.A_is_zero) begin
			// x0 style operand, ready at once
			operand = '0;
			operand_available = 1'b1;
		end else if (entry.A_forward) begin
			// bypass only lives for the cycle right after issue
			operand = forward_data_by_bank[entry.A_bank];
			operand_available = first_cycle;
		end else begin
			// regular read, bank from issue, port from the read grant
			operand = reg_read_data_by_bank_by_port[entry.A_bank][A_reg_read_port];
			operand_available = A_reg_read_ack;
		end
	end

	// zero wins over forward if both flags are set
	// the caller gates availability with its own occupancy state

endmodule

// ==== ldu_addr_pkg.sv ====
package ldu_addr_pkg;

	// ---------------------------------------------------------------------
	// sizes

	// register file banking
	localparam int PRF_BANK_COUNT = 4;
	localparam int LOG_PRF_BANK_COUNT = $clog2(PRF_BANK_COUNT);

	// completion queue depth
	localparam int LDU_CQ_ENTRIES = 16;
	localparam int LOG_LDU_CQ_ENTRIES = $clog2(LDU_CQ_ENTRIES);

	// 4 KiB pages, 32-bit virtual address
	localparam int VPN_WIDTH = 20;
	localparam int PO_WIDTH = 12;

	// ---------------------------------------------------------------------
	// vector types

	typedef logic [31:0] word_t;
	typedef logic [11:0] imm12_t;
	// [1:0] size (0 byte, 1 half, 2/3 word), [2] unsigned
	typedef logic [3:0] load_op_t;
	typedef logic [LOG_PRF_BANK_COUNT-1:0] prf_bank_t;
	typedef logic [LOG_LDU_CQ_ENTRIES-1:0] cq_index_t;
	typedef logic [VPN_WIDTH-1:0] vpn_t;
	// page offset without the two byte bits
	typedef logic [PO_WIDTH-3:0] po_word_t;
	typedef logic [3:0] byte_mask_t;

	// operand collect stage
	typedef enum logic [1:0] {
		OC_EMPTY,
		OC_WAIT_READ,
		OC_HOLD
	} oc_state_t;

	// ---------------------------------------------------------------------
	// structs

	// op as it comes out of the issue queue
	typedef struct packed {
		logic valid;
		load_op_t op;
		imm12_t imm12;
		logic A_forward;
		logic A_is_zero;
		prf_bank_t A_bank;
		cq_index_t cq_index;
	} ldu_issue_t;

	// request toward the completion and misaligned queues
	typedef struct packed {
		logic valid_cq;
		logic valid_mq;
		logic misaligned;
		vpn_t VPN;
		po_word_t PO_word;
		byte_mask_t byte_mask;
		cq_index_t cq_index;
	} ldu_req_t;

endpackage
